//--- src/kernel_farm_defs.svh
/* Sizes shared by the farm RTL and bench. KF_TAG_W must address all KF_MEM_DEPTH words,
   and KF_N_W bounds the iteration count of every kernel. */

`ifndef KERNEL_FARM_DEFS_SVH
`define KERNEL_FARM_DEFS_SVH

// Number of identical kernel workers
`define KF_NUM_WORKERS 4

// Result memory depth in words
`define KF_MEM_DEPTH   64

// Result slot address width
`define KF_TAG_W       6

// Argument n width, n runs 0..31
`define KF_N_W         5

// Result word width
`define KF_DATA_W      32

`endif

//--- src/kernel_farm_pkg.sv
/* Job and result payload types for the farm. Widths come from kernel_farm_defs.svh. */

`default_nettype none

`include "kernel_farm_defs.svh"

package kernel_farm_pkg;

    // Kernel selector carried with each job
    typedef enum logic {
        KERNEL_DOUBLER = 1'b0,
        KERNEL_FIB     = 1'b1
    } kernel_e;

    // ------------------------------------------------------------
    // Host job, 12 bits
    // ------------------------------------------------------------
    typedef struct packed {
        kernel_e               kind;
        logic [`KF_N_W-1:0]    n;
        logic [`KF_TAG_W-1:0]  tag;
    } job_t;

    // ------------------------------------------------------------
    // Finished result, 38 bits
    // ------------------------------------------------------------
    typedef struct packed {
        logic [`KF_TAG_W-1:0]  tag;
        logic [`KF_DATA_W-1:0] value;
    } result_t;

endpackage

`default_nettype wire

//--- src/job_dispatcher.sv
/* Takes one host job at a time and hands it to the lowest idle worker.
   job_ack rises only once the chosen worker has acked the job. */

`timescale 1ns/1ps
`default_nettype none

`include "kernel_farm_defs.svh"

module job_dispatcher (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        job_req,
    output logic                        job_ack,
    input  kernel_farm_pkg::job_t       job,
    output logic [`KF_NUM_WORKERS-1:0]  work_req,
    input  logic [`KF_NUM_WORKERS-1:0]  work_ack,
    output kernel_farm_pkg::job_t       work_job,
    input  logic [`KF_NUM_WORKERS-1:0]  worker_idle
);
    import kernel_farm_pkg::*;

    typedef enum logic [1:0] {
        D_IDLE,
        D_WAIT,
        D_SEND,
        D_ACK
    } disp_state_e;

    disp_state_e                 state;
    logic [`KF_NUM_WORKERS-1:0]  pick;
    logic                        accept;

    // Lowest set bit of the idle mask
    assign pick   = worker_idle & (~worker_idle + 1'b1);
    assign accept = (state == D_IDLE) && job_req;

    // ------------------------------------------------------------
    // Handshake FSM
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= D_IDLE;
            job_ack  <= 1'b0;
            work_req <= '0;
        end else begin
            case (state)
                D_IDLE: begin
                    if (job_req) begin
                        // Forward at once when a worker is free
                        if (|worker_idle) begin
                            work_req <= pick;
                            state    <= D_SEND;
                        end else begin
                            state <= D_WAIT;
                        end
                    end
                end
                D_WAIT: begin
                    if (|worker_idle) begin
                        work_req <= pick;
                        state    <= D_SEND;
                    end
                end
                D_SEND: begin
                    // Chosen worker has taken the job
                    if (|(work_ack & work_req)) begin
                        work_req <= '0;
                        job_ack  <= 1'b1;
                        state    <= D_ACK;
                    end
                end
                default: begin
                    if (!job_req) begin
                        job_ack <= 1'b0;
                        state   <= D_IDLE;
                    end
                end
            endcase
        end
    end

    // Job payload held from acceptance to worker ack
    always_ff @(posedge clk) begin
        if (accept) begin
            work_job <= job;
        end
    end

    // Only one worker is ever offered a job
    a_one_work_req: assert property (@(posedge clk) disable iff (rst) $onehot0(work_req));

endmodule

`default_nettype wire

//--- src/kernel_worker.sv
/* Iterative doubler or fibonacci engine, one step per cycle. A job takes n cycles
   plus the result handshake; the worker is not idle until res_ack has fallen. */

`timescale 1ns/1ps
`default_nettype none

`include "kernel_farm_defs.svh"

module kernel_worker (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     work_req,
    output logic                     work_ack,
    input  kernel_farm_pkg::job_t    work_job,
    output logic                     res_req,
    input  logic                     res_ack,
    output kernel_farm_pkg::result_t res_data,
    output logic                     idle
);
    import kernel_farm_pkg::*;

    typedef enum logic [1:0] {
        W_IDLE,
        W_RUN,
        W_RESULT,
        W_RELEASE
    } work_state_e;

    work_state_e           state;
    job_t                  job_q;
    logic [`KF_N_W-1:0]    iter_cnt;
    logic [`KF_DATA_W-1:0] a;
    logic [`KF_DATA_W-1:0] b;
    logic [`KF_DATA_W-1:0] c;
    logic                  take;

    // New job only once the previous work_ack has dropped
    assign take = (state == W_IDLE) && work_req && !work_ack;

    // ------------------------------------------------------------
    // Job side handshake
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            work_ack <= 1'b0;
        end else if (take) begin
            work_ack <= 1'b1;
        end else if (!work_req) begin
            work_ack <= 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Control FSM and iteration count
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= W_IDLE;
            res_req  <= 1'b0;
            iter_cnt <= '0;
        end else begin
            case (state)
                W_IDLE: begin
                    if (take) begin
                        iter_cnt <= work_job.n;
                        state    <= W_RUN;
                    end
                end
                W_RUN: begin
                    if (iter_cnt == '0) begin
                        res_req <= 1'b1;
                        state   <= W_RESULT;
                    end else begin
                        iter_cnt <= iter_cnt - 1'b1;
                    end
                end
                W_RESULT: begin
                    if (res_ack) begin
                        res_req <= 1'b0;
                        state   <= W_RELEASE;
                    end
                end
                default: begin
                    // Back to idle on the fall of res_ack
                    if (!res_ack) begin
                        state <= W_IDLE;
                    end
                end
            endcase
        end
    end

    // Kernel datapath
    always_ff @(posedge clk) begin
        if (take) begin
            job_q <= work_job;
            a     <= (work_job.kind == KERNEL_FIB) ? '0 : `KF_DATA_W'(1);
            b     <= `KF_DATA_W'(1);
            c     <= '0;
        end else if (state == W_RUN && iter_cnt != '0) begin
            if (job_q.kind == KERNEL_FIB) begin
                c <= a + b;
                a <= b;
                b <= a + b;
            end else begin
                a <= a << 1;
            end
        end
    end

    // Result stays put while res_req is high
    always_comb begin
        res_data.tag   = job_q.tag;
        res_data.value = (job_q.kind == KERNEL_FIB) ? c : a;
    end

    assign idle = (state == W_IDLE);

    // Ack only answers a live request
    a_ack_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(work_ack) |-> $past(work_req));

endmodule

`default_nettype wire

//--- src/result_store.sv
/* Single-port result memory with host reads ahead of worker writes. Memory is not
   cleared at reset; rd_data is valid one cycle after rd_en. */

`timescale 1ns/1ps
`default_nettype none

`include "kernel_farm_defs.svh"

module result_store (
    input  logic                        clk,
    input  logic                        rst,
    input  logic [`KF_NUM_WORKERS-1:0]  res_req,
    output logic [`KF_NUM_WORKERS-1:0]  res_ack,
    input  kernel_farm_pkg::result_t    res_data [`KF_NUM_WORKERS],
    input  logic                        rd_en,
    input  logic [`KF_TAG_W-1:0]        rd_addr,
    output logic [`KF_DATA_W-1:0]       rd_data,
    output logic                        pending
);
    import kernel_farm_pkg::*;

    localparam int SEL_W = $clog2(`KF_NUM_WORKERS);

    logic [`KF_NUM_WORKERS-1:0] open_req;
    logic [`KF_NUM_WORKERS-1:0] grant;
    logic [SEL_W-1:0]           wr_sel;
    logic                       wr_en;
    result_t                    wr_res;

    logic [`KF_DATA_W-1:0]      mem [`KF_MEM_DEPTH];

    // Requests not yet acknowledged
    assign open_req = res_req & ~res_ack;

    // ------------------------------------------------------------
    // Fixed priority arbiter
    // ------------------------------------------------------------
    always_comb begin
        grant  = '0;
        wr_sel = '0;
        // Host read owns the port this cycle
        if (!rd_en) begin
            // Walk down so the lowest index wins
            for (int i = `KF_NUM_WORKERS - 1; i >= 0; i--) begin
                if (open_req[i]) begin
                    grant    = '0;
                    grant[i] = 1'b1;
                    wr_sel   = SEL_W'(i);
                end
            end
        end
    end

    assign wr_en  = |grant;
    assign wr_res = res_data[wr_sel];

    // Ack rises with the write, falls once the worker drops req
    always_ff @(posedge clk) begin
        if (rst) begin
            res_ack <= '0;
        end else begin
            res_ack <= (res_ack | grant) & res_req;
        end
    end

    // ------------------------------------------------------------
    // Memory port, one access per cycle
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end else if (wr_en) begin
            mem[wr_res.tag] <= wr_res.value;
        end
    end

    assign pending = |res_req;

    a_grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant));

    // Workers hold req until acked, so a stalled write is never lost
    a_req_held: assert property (@(posedge clk) disable iff (rst)
        ((~res_req) & $past(res_req & ~res_ack)) == '0);

endmodule

`default_nettype wire

//--- src/kernel_farm_top.sv
/* Farm top: dispatcher, worker array and result store. busy covers a job from
   worker pickup until its result is written and released. */

`timescale 1ns/1ps
`default_nettype none

`include "kernel_farm_defs.svh"

module kernel_farm_top (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   job_req,
    output logic                   job_ack,
    input  kernel_farm_pkg::job_t  job,
    input  logic                   rd_en,
    input  logic [`KF_TAG_W-1:0]   rd_addr,
    output logic [`KF_DATA_W-1:0]  rd_data,
    output logic                   busy
);
    import kernel_farm_pkg::*;

    logic [`KF_NUM_WORKERS-1:0] work_req;
    logic [`KF_NUM_WORKERS-1:0] work_ack;
    logic [`KF_NUM_WORKERS-1:0] worker_idle;
    logic [`KF_NUM_WORKERS-1:0] res_req;
    logic [`KF_NUM_WORKERS-1:0] res_ack;
    job_t                       work_job;
    result_t                    res_data [`KF_NUM_WORKERS];
    logic                       pending;

    // ------------------------------------------------------------
    // Job intake
    // ------------------------------------------------------------
    job_dispatcher u_dispatcher (
        .clk         (clk),
        .rst         (rst),
        .job_req     (job_req),
        .job_ack     (job_ack),
        .job         (job),
        .work_req    (work_req),
        .work_ack    (work_ack),
        .work_job    (work_job),
        .worker_idle (worker_idle)
    );

    // Workers share the job bus, only one sees req
    for (genvar i = 0; i < `KF_NUM_WORKERS; i++) begin : g_worker
        kernel_worker u_worker (
            .clk      (clk),
            .rst      (rst),
            .work_req (work_req[i]),
            .work_ack (work_ack[i]),
            .work_job (work_job),
            .res_req  (res_req[i]),
            .res_ack  (res_ack[i]),
            .res_data (res_data[i]),
            .idle     (worker_idle[i])
        );
    end

    // Result drain and host readback
    result_store u_store (
        .clk     (clk),
        .rst     (rst),
        .res_req (res_req),
        .res_ack (res_ack),
        .res_data(res_data),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .pending (pending)
    );

    // Any worker active or any write still queued
    assign busy = ~(&worker_idle) | pending;

endmodule

`default_nettype wire

//--- bench/tb_clock_gen.sv
/* Free-running 40 ns clock. rst is held high for 10 rising edges and
   released 2 ns after the last one, in step with the stimulus. */

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst
);
    localparam int HALF_PERIOD  = 20;
    localparam int RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    // Release off the edge, like every other input
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
    end

endmodule

`default_nettype wire

//--- bench/tb_checker.sv
/* Watches the host ports of the farm. Expected words come from the jobs seen on
   the job port; a tag must not be read while its own job is still in flight. */

`timescale 1ns/1ps
`default_nettype none

`include "kernel_farm_defs.svh"

module tb_checker (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      job_req,
    input  logic                      job_ack,
    input  kernel_farm_pkg::job_t     job,
    input  logic                      rd_en,
    input  logic [`KF_TAG_W-1:0]      rd_addr,
    input  logic [`KF_DATA_W-1:0]     rd_data,
    input  logic                      busy,
    input  logic                      report,
    output int                        errors,
    output int                        checks
);
    import kernel_farm_pkg::*;

    logic [`KF_DATA_W-1:0] exp_mem [`KF_MEM_DEPTH];
    logic                  exp_valid [`KF_MEM_DEPTH];
    logic                  rst_q = 1'b0;
    logic                  job_req_q = 1'b0;
    logic                  rd_pend = 1'b0;
    logic [`KF_TAG_W-1:0]  rd_addr_q = '0;
    int                    err_cnt = 0;
    int                    chk_cnt = 0;

    assign errors = err_cnt;
    assign checks = chk_cnt;

    // Doubler, a = 1 doubled n times
    function automatic logic [`KF_DATA_W-1:0] doubler_model(input int n);
        logic [`KF_DATA_W-1:0] a;
        a = 1;
        for (int i = 0; i < n; i++) begin
            a = a << 1;
        end
        return a;
    endfunction

    // Fibonacci step rule, result is c
    function automatic logic [`KF_DATA_W-1:0] fib_model(input int n);
        logic [`KF_DATA_W-1:0] a;
        logic [`KF_DATA_W-1:0] b;
        logic [`KF_DATA_W-1:0] c;
        a = 0;
        b = 1;
        c = 0;
        for (int i = 0; i < n; i++) begin
            c = a + b;
            a = b;
            b = c;
        end
        return c;
    endfunction

    initial begin
        for (int i = 0; i < `KF_MEM_DEPTH; i++) begin
            exp_valid[i] = 1'b0;
        end
    end

    // ------------------------------------------------------------
    // Sampled mid-cycle, away from both edges
    // ------------------------------------------------------------
    always @(negedge clk) begin
        // Read launched at the previous edge is due now
        if (rd_pend) begin
            chk_cnt++;
            if (!exp_valid[rd_addr_q]) begin
                err_cnt++;
                $display("Read of tag %0d at %0t, but no job ever targeted it",
                         rd_addr_q, $time);
            end else if (rd_data !== exp_mem[rd_addr_q]) begin
                err_cnt++;
                $display("CHECK FAILED t=%0t rd_data tag %0d: got %h expected %h",
                         $time, rd_addr_q, rd_data, exp_mem[rd_addr_q]);
            end else begin
                $display("read tag %0d: %h as expected", rd_addr_q, rd_data);
            end
        end
        rd_pend   = rd_en;
        rd_addr_q = rd_addr;

        // New job, payload stable from the rise of job_req
        if (job_req && !job_req_q) begin
            exp_valid[job.tag] = 1'b1;
            if (job.kind == KERNEL_FIB) begin
                exp_mem[job.tag] = fib_model(int'(job.n));
            end else begin
                exp_mem[job.tag] = doubler_model(int'(job.n));
            end
        end
        job_req_q = job_req;

        // First mid-cycle after reset release
        if (rst_q && !rst) begin
            chk_cnt++;
            if (job_ack !== 1'b0 || busy !== 1'b0) begin
                err_cnt++;
                $display("CHECK FAILED t=%0t job_ack/busy after reset: got %b/%b expected 0/0",
                         $time, job_ack, busy);
            end else begin
                $display("reset: job_ack and busy low");
            end
        end
        rst_q = rst;
    end

    always @(posedge report) begin
        $display("Checks: %0d run, %0d passed, %0d failed",
                 chk_cnt, chk_cnt - err_cnt, err_cnt);
    end

endmodule

`default_nettype wire

//--- bench/tb_kernel_farm.sv
/* Host side of the farm: table of 20 jobs, LFSR gaps, read bursts under load and
   a full readback of every used tag. Inputs move 2 ns after the rising edge. */

`timescale 1ns/1ps
`default_nettype none

`include "kernel_farm_defs.svh"

module tb_kernel_farm;
    import kernel_farm_pkg::*;

    localparam int NUM_TESTS      = 20;
    localparam int TIMEOUT_CYCLES = NUM_TESTS * 50 + `KF_MEM_DEPTH * 4 + 200;
    localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;

    // One table row, flags steer the host sequence
    typedef struct packed {
        kernel_e               kind;
        logic [`KF_N_W-1:0]    n;
        logic [`KF_TAG_W-1:0]  tag;
        logic                  drain_first;
        logic                  no_gap;
        logic                  read_after;
    } stim_t;

    logic                  clk;
    logic                  rst;
    logic                  job_req;
    logic                  job_ack;
    job_t                  job;
    logic                  rd_en;
    logic [`KF_TAG_W-1:0]  rd_addr;
    logic [`KF_DATA_W-1:0] rd_data;
    logic                  busy;
    logic                  report;
    int                    err_cnt;
    int                    chk_cnt;
    int                    reads_issued;
    int                    cycle_cnt = 0;
    int                    gap;
    logic [31:0]           lfsr_state;
    logic                  used [`KF_MEM_DEPTH];
    stim_t                 stim [NUM_TESTS];

    tb_clock_gen u_clk_gen (
        .clk (clk),
        .rst (rst)
    );

    kernel_farm_top dut (
        .clk     (clk),
        .rst     (rst),
        .job_req (job_req),
        .job_ack (job_ack),
        .job     (job),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .busy    (busy)
    );

    tb_checker u_checker (
        .clk     (clk),
        .rst     (rst),
        .job_req (job_req),
        .job_ack (job_ack),
        .job     (job),
        .rd_en   (rd_en),
        .rd_addr (rd_addr),
        .rd_data (rd_data),
        .busy    (busy),
        .report  (report),
        .errors  (err_cnt),
        .checks  (chk_cnt)
    );

    function automatic stim_t make_entry(input kernel_e kind, input int n, input int tag,
                                         input logic drain, input logic nogap,
                                         input logic rdafter);
        stim_t e;
        e.kind        = kind;
        e.n           = `KF_N_W'(n);
        e.tag         = `KF_TAG_W'(tag);
        e.drain_first = drain;
        e.no_gap      = nogap;
        e.read_after  = rdafter;
        return e;
    endfunction

    // Galois LFSR, right shifting
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        if (s[0]) begin
            return (s >> 1) ^ LFSR_TAPS;
        end
        return s >> 1;
    endfunction

    // Three bits, one step each, gap 0..7
    task automatic draw_gap(output int g);
        int acc;
        acc = 0;
        for (int k = 0; k < 3; k++) begin
            acc = acc | (int'(lfsr_state[0]) << k);
            lfsr_state = lfsr_step(lfsr_state);
        end
        g = acc;
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    // Full four-phase handshake on the job port
    task automatic issue_job(input stim_t s);
        job.kind = s.kind;
        job.n    = s.n;
        job.tag  = s.tag;
        job_req  = 1'b1;
        do next_cycle(); while (!job_ack);
        job_req = 1'b0;
        do next_cycle(); while (job_ack);
    endtask

    task automatic wait_idle();
        while (busy) begin
            next_cycle();
        end
    endtask

    // rd_en stays high across calls, caller drops it
    task automatic read_tag(input logic [`KF_TAG_W-1:0] tag);
        rd_en   = 1'b1;
        rd_addr = tag;
        reads_issued++;
        next_cycle();
    endtask

    // ------------------------------------------------------------
    // Timeout watchdog
    // ------------------------------------------------------------
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    initial begin
        wait (cycle_cnt >= TIMEOUT_CYCLES);
        $display("Run did not finish within %0d cycles", TIMEOUT_CYCLES);
        $display("Simulation finished: FAIL");
        $finish;
    end

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial begin
        job_req      = 1'b0;
        job          = '0;
        rd_en        = 1'b0;
        rd_addr      = '0;
        report       = 1'b0;
        reads_issued = 0;
        lfsr_state   = 32'd82601;
        for (int t = 0; t < `KF_MEM_DEPTH; t++) begin
            used[t] = 1'b0;
        end

        // Basic results for both kernels
        stim[0]  = make_entry(KERNEL_DOUBLER, 0, 0, 1'b0, 1'b0, 1'b0);
        stim[1]  = make_entry(KERNEL_DOUBLER, 1, 1, 1'b0, 1'b0, 1'b0);
        stim[2]  = make_entry(KERNEL_DOUBLER, 17, 2, 1'b0, 1'b0, 1'b0);
        stim[3]  = make_entry(KERNEL_DOUBLER, 31, 3, 1'b0, 1'b0, 1'b0);
        stim[4]  = make_entry(KERNEL_FIB, 0, 4, 1'b0, 1'b0, 1'b0);
        stim[5]  = make_entry(KERNEL_FIB, 1, 5, 1'b0, 1'b0, 1'b0);
        stim[6]  = make_entry(KERNEL_FIB, 2, 6, 1'b0, 1'b0, 1'b0);
        stim[7]  = make_entry(KERNEL_FIB, 31, 7, 1'b0, 1'b0, 1'b0);
        // Eight back to back, mixed n so they finish out of order
        stim[8]  = make_entry(KERNEL_FIB, 25, 16, 1'b1, 1'b1, 1'b0);
        stim[9]  = make_entry(KERNEL_DOUBLER, 3, 17, 1'b0, 1'b1, 1'b0);
        stim[10] = make_entry(KERNEL_FIB, 19, 18, 1'b0, 1'b1, 1'b0);
        stim[11] = make_entry(KERNEL_DOUBLER, 0, 19, 1'b0, 1'b1, 1'b0);
        stim[12] = make_entry(KERNEL_FIB, 12, 20, 1'b0, 1'b1, 1'b0);
        stim[13] = make_entry(KERNEL_DOUBLER, 29, 21, 1'b0, 1'b1, 1'b0);
        stim[14] = make_entry(KERNEL_FIB, 1, 22, 1'b0, 1'b1, 1'b0);
        stim[15] = make_entry(KERNEL_DOUBLER, 8, 23, 1'b0, 1'b1, 1'b1);
        // Overwrites of used tags once the farm is idle
        stim[16] = make_entry(KERNEL_FIB, 9, 3, 1'b1, 1'b0, 1'b0);
        stim[17] = make_entry(KERNEL_DOUBLER, 5, 7, 1'b0, 1'b0, 1'b0);
        stim[18] = make_entry(KERNEL_FIB, 30, 18, 1'b0, 1'b0, 1'b0);
        stim[19] = make_entry(KERNEL_DOUBLER, 2, 63, 1'b0, 1'b0, 1'b0);

        @(negedge rst);
        next_cycle();

        for (int i = 0; i < NUM_TESTS; i++) begin
            if (stim[i].drain_first) begin
                wait_idle();
            end
            issue_job(stim[i]);
            used[stim[i].tag] = 1'b1;
            // Reads of settled tags while writes queue up
            if (stim[i].read_after) begin
                for (int r = 0; r < 16; r++) begin
                    read_tag(stim[r % 8].tag);
                end
                rd_en = 1'b0;
            end
            if (!stim[i].no_gap) begin
                draw_gap(gap);
                repeat (gap) next_cycle();
            end
        end

        // Final readback, pipelined one read per cycle
        wait_idle();
        for (int t = 0; t < `KF_MEM_DEPTH; t++) begin
            if (used[t]) begin
                read_tag(`KF_TAG_W'(t));
            end
        end
        rd_en = 1'b0;
        repeat (2) next_cycle();

        report = 1'b1;
        #1;
        if (chk_cnt != reads_issued + 1) begin
            $display("Only %0d of %0d expected checks were run", chk_cnt, reads_issued + 1);
        end
        if (err_cnt == 0 && chk_cnt == reads_issued + 1) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- kernel_farm.f
+incdir+src
src/kernel_farm_pkg.sv
src/job_dispatcher.sv
src/kernel_worker.sv
src/result_store.sv
src/kernel_farm_top.sv
bench/tb_clock_gen.sv
bench/tb_checker.sv
bench/tb_kernel_farm.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the kernel_farm testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_kernel_farm -f kernel_farm.f

out=$(./obj_dir/Vtb_kernel_farm) || true
echo "$out"

if echo "$out" | grep -q -x -F "Simulation finished: PASS"; then
    exit 0
fi
exit 1
